// File: sim.f
hw/histPkg.sv
hw/binRam.sv
hw/binDecode.sv
hw/binUpdate.sv
hw/peakReadout.sv
hw/histogramTop.sv
sim/histTb.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the histogram testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f --top-module histTb -o histTb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/histTb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the testbench decides, the script only looks for its verdict
if grep -q "All checks passed" <<< "$output"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

// File: sim/histTb.sv
`timescale 1ns/100ps
`default_nettype none

module histTb
    import histPkg::*;
();

    localparam int numRandom = 200;
    localparam int burstLen  = 30;
    localparam int burstBin  = 37;
    localparam int wordTotal = 2 + numRandom + 2 + 1 + 15 + burstLen + 2;
    localparam int waitLimit = 2000;  // cycles per wait loop

    logic                    clk;
    logic                    res;
    logic                    inValid;
    histWord                 inWord;
    logic                    outCreditRet;
    logic                    inCreditRet;
    logic                    outValid;
    logic                    outPeak;
    logic [binAddrWidth-1:0] outBin;
    logic [countWidth-1:0]   outCount;

    logic [countWidth-1:0]   model [binCount];       // reference histogram
    logic [countWidth-1:0]   prevCounts [binCount];  // last readout seen
    int                      seed = 32'hfbb1;
    int                      wordsSent = 0;
    int                      creditsBack = 0;
    int                      expBin = 0;
    int                      peaksSeen = 0;
    int                      held = 0;               // words the sink still owns
    int                      owed = 0;               // credits not yet returned
    int                      returnDelay = 0;
    bit                      compareWithPrev = 1'b0;

    histogramTop u_dut (
        .clk          (clk),
        .res          (res),
        .inValid      (inValid),
        .inWord       (inWord),
        .outCreditRet (outCreditRet),
        .inCreditRet  (inCreditRet),
        .outValid     (outValid),
        .outPeak      (outPeak),
        .outBin       (outBin),
        .outCount     (outCount)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic abortRun();
        $display("Checks failed");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic failCheck(input string msg);
        $display("error at %0d ns: %s", $time, msg);
        abortRun();
    endtask

    // lowest bin holding the largest model count
    function automatic int peakBinOf();
        int best;
        best = 0;
        for (int b = 1; b < binCount; b++) begin
            if (model[b] > model[best]) begin
                best = b;  // strict compare
            end
        end
        return best;
    endfunction

    task automatic clearModel();
        for (int b = 0; b < binCount; b++) begin
            model[b] = '0;
        end
    endtask

    // entered and left at 1 ns after a rising edge
    task automatic sendWord(input histWord w);
        int waited;
        waited = 0;
        while (wordsSent - creditsBack >= inCredits) begin  // no credit left
            @(posedge clk);
            #1;
            waited++;
            if (waited > waitLimit) begin
                $display("the DUT never returned an input credit");
                abortRun();
            end
        end
        inValid = 1'b1;
        inWord  = w;
        wordsSent++;
        @(posedge clk);
        #1;
        inValid = 1'b0;
    endtask

    task automatic sendSample(input logic [binAddrWidth-1:0] bin);
        histWord     w;
        logic [31:0] rnd;
        rnd = $random(seed);
        w = '0;
        w.sample.bin    = bin;
        w.sample.unused = rnd[sampleWidth-binAddrWidth-2:0];  // junk the DUT must ignore
        sendWord(w);
        if (model[bin] != '1) begin
            model[bin] = model[bin] + 1'b1;  // saturates like the DUT
        end
    endtask

    task automatic sendCommand(input logic [1:0] op);
        histWord w;
        w = '0;
        w.cmd.kind = 1'b1;
        w.cmd.op   = op;
        sendWord(w);
    endtask

    task automatic runReadout(input bit repeatCheck);
        int startPeaks;
        int waited;
        startPeaks      = peaksSeen;
        waited          = 0;
        compareWithPrev = repeatCheck;
        sendCommand(opReadout);
        while (peaksSeen == startPeaks) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > waitLimit) begin
                $display("readout never delivered its peak word");
                abortRun();
            end
        end
    endtask

    always @(posedge clk) begin
        if (inCreditRet) begin
            creditsBack++;
            assert (creditsBack <= wordsSent)
                else failCheck("input credit returned with no word outstanding");
        end
    end

    // output sink checking every word
    always @(posedge clk) begin
        if (outValid) begin
            assert (held < outCredits)
                else failCheck("outValid raised without an output credit");
            if (!outPeak) begin
                assert (expBin < binCount)
                    else failCheck("more bin counts than bins in one readout");
                assert (int'(outBin) == expBin)
                    else failCheck($sformatf("bin %0d out of order, expected %0d",
                                             outBin, expBin));
                if (compareWithPrev) begin
                    assert (outCount == prevCounts[expBin])
                        else failCheck($sformatf("bin %0d count %0d, first readout %0d",
                                                 expBin, outCount, prevCounts[expBin]));
                end else begin
                    assert (outCount == model[expBin])
                        else failCheck($sformatf("bin %0d count %0d, expected %0d",
                                                 expBin, outCount, model[expBin]));
                end
                prevCounts[expBin] = outCount;
                expBin++;
            end else begin
                assert (expBin == binCount)
                    else failCheck($sformatf("peak word after %0d counts", expBin));
                assert (int'(outBin) == peakBinOf())
                    else failCheck($sformatf("peak bin %0d, expected %0d",
                                             outBin, peakBinOf()));
                assert (outCount == model[peakBinOf()])
                    else failCheck($sformatf("peak count %0d, expected %0d",
                                             outCount, model[peakBinOf()]));
                expBin = 0;
                peaksSeen++;
            end
            owed++;
        end
        held = held + (outValid ? 1 : 0) - (outCreditRet ? 1 : 0);
    end

    always @(posedge clk) begin
        #1;
        if (owed > 0 && returnDelay == 0) begin
            outCreditRet = 1'b1;
            owed--;
            returnDelay = $random(seed) & 3;  // next return 0..3 cycles later
        end else begin
            outCreditRet = 1'b0;
            if (returnDelay > 0) begin
                returnDelay--;
            end
        end
    end

    initial begin
        #(wordTotal * 200 + 5000);
        $display("watchdog expired at %0d ns, the DUT stopped making progress", $time);
        abortRun();
    end

    initial begin
        int          waited;
        logic [31:0] rnd;
        res          = 1'b0;
        inValid      = 1'b0;
        inWord       = '0;
        outCreditRet = 1'b0;
        clearModel();
        repeat (4) @(posedge clk);
        #1;
        res = 1'b1;

        sendCommand(opClear);  // all zeros with the peak at bin 0
        runReadout(1'b0);

        for (int i = 0; i < numRandom; i++) begin
            rnd = $random(seed);
            sendSample(rnd[binAddrWidth-1:0]);
            if (rnd[31]) begin
                @(posedge clk);  // idle gap now and then
                #1;
            end
        end
        sendCommand(2'd0);     // undefined opcode gets dropped
        runReadout(1'b0);
        runReadout(1'b1);      // must repeat unchanged

        sendCommand(opClear);
        clearModel();
        for (int i = 0; i < 5; i++) begin
            sendSample(6'd40);
            sendSample(6'd12);  // ties with 40 so the lower bin wins
            if (i < 3) begin
                sendSample(6'd3);
            end
        end
        runReadout(1'b0);

        sendCommand(opClear);
        clearModel();
        for (int i = 0; i < burstLen; i++) begin
            sendSample(burstBin);  // back to back on one bin
        end
        runReadout(1'b0);

        waited = 0;
        while (creditsBack != wordsSent) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > waitLimit) begin
                $display("input credits missing at the end, a word was lost");
                abortRun();
            end
        end
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/histogramTop.sv
`timescale 1ns/100ps
`default_nettype none

module histogramTop
    import histPkg::*;
(
    input  logic                    clk,
    input  logic                    res,
    input  logic                    inValid,
    input  histWord                 inWord,
    input  logic                    outCreditRet,
    output logic                    inCreditRet,
    output logic                    outValid,
    output logic                    outPeak,
    output logic [binAddrWidth-1:0] outBin,
    output logic [countWidth-1:0]   outCount
);

    logic                    updValid;
    logic [binAddrWidth-1:0] updBin;
    logic                    cmdValid;
    logic [1:0]              cmdOp;
    logic                    busy;
    logic                    scanStart;
    logic                    scanDone;
    logic [binAddrWidth-1:0] scanAddr;
    logic [countWidth-1:0]   scanCount;

    binDecode uDecode (
        .clk         (clk),
        .res         (res),
        .inValid     (inValid),
        .inWord      (inWord),
        .busy        (busy),
        .inCreditRet (inCreditRet),
        .updValid    (updValid),
        .updBin      (updBin),
        .cmdValid    (cmdValid),
        .cmdOp       (cmdOp)
    );

    binUpdate uExecute (
        .clk       (clk),
        .res       (res),
        .updValid  (updValid),
        .updBin    (updBin),
        .cmdValid  (cmdValid),
        .cmdOp     (cmdOp),
        .scanAddr  (scanAddr),
        .scanDone  (scanDone),
        .busy      (busy),
        .scanStart (scanStart),
        .scanBusy  (),
        .scanCount (scanCount)
    );

    peakReadout uResult (
        .clk          (clk),
        .res          (res),
        .scanStart    (scanStart),
        .scanCount    (scanCount),
        .outCreditRet (outCreditRet),
        .scanAddr     (scanAddr),
        .scanDone     (scanDone),
        .outValid     (outValid),
        .outPeak      (outPeak),
        .outBin       (outBin),
        .outCount     (outCount)
    );

endmodule

`default_nettype wire

// File: hw/peakReadout.sv
`timescale 1ns/100ps
`default_nettype none

module peakReadout
    import histPkg::*;
(
    input  logic                    clk,
    input  logic                    res,
    input  logic                    scanStart,
    input  logic [countWidth-1:0]   scanCount,
    input  logic                    outCreditRet,
    output logic [binAddrWidth-1:0] scanAddr,
    output logic                    scanDone,
    output logic                    outValid,
    output logic                    outPeak,
    output logic [binAddrWidth-1:0] outBin,
    output logic [countWidth-1:0]   outCount
);

    logic [$clog2(outCredits+1)-1:0] credits;
    logic [$clog2(outCredits+1)-1:0] freeCredits;
    logic                            active;       // bins left to read
    logic                            issue;
    logic                            rspValid;     // scanCount is live
    logic [binAddrWidth-1:0]         rspBin;
    logic                            peakPending;
    logic                            peakSend;
    logic [binAddrWidth-1:0]         peakBin;
    logic [countWidth-1:0]           peakCount;

    // a read in flight already has its credit reserved
    assign freeCredits = rspValid ? credits - 1'b1 : credits;
    assign issue       = active && (freeCredits != '0);
    assign peakSend    = peakPending && !rspValid && (credits != '0);

    assign outValid = rspValid || peakSend;
    assign outPeak  = peakSend;
    assign outBin   = peakSend ? peakBin : rspBin;
    assign outCount = peakSend ? peakCount : scanCount;
    assign scanDone = peakSend;  // releases the read port

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            active      <= 1'b0;
            scanAddr    <= '0;
            rspValid    <= 1'b0;
            peakPending <= 1'b0;
            credits     <= ($clog2(outCredits+1))'(outCredits);
        end else begin
            if (scanStart) begin
                active   <= 1'b1;
                scanAddr <= '0;
            end else if (issue) begin
                scanAddr <= scanAddr + 1'b1;  // held while out of credits
                if (scanAddr == binAddrWidth'(binCount - 1)) begin
                    active      <= 1'b0;
                    peakPending <= 1'b1;
                end
            end
            if (peakSend) begin
                peakPending <= 1'b0;
            end
            rspValid <= issue;

            case ({outCreditRet, outValid})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        rspBin <= scanAddr;
        if (scanStart) begin
            peakCount <= '0;
            peakBin   <= '0;
        end else if (rspValid && scanCount > peakCount) begin
            peakCount <= scanCount;  // strict compare keeps the lowest bin
            peakBin   <= rspBin;
        end
    end

endmodule

`default_nettype wire

// File: hw/binUpdate.sv
`timescale 1ns/100ps
`default_nettype none

module binUpdate
    import histPkg::*;
(
    input  logic                    clk,
    input  logic                    res,
    input  logic                    updValid,
    input  logic [binAddrWidth-1:0] updBin,
    input  logic                    cmdValid,
    input  logic [1:0]              cmdOp,
    input  logic [binAddrWidth-1:0] scanAddr,
    input  logic                    scanDone,
    output logic                    busy,
    output logic                    scanStart,
    output logic                    scanBusy,
    output logic [countWidth-1:0]   scanCount
);

    logic                    s1Valid;   // read issued, write this cycle
    logic [binAddrWidth-1:0] s1Bin;
    logic                    fwdValid;  // last cycle's write
    logic [binAddrWidth-1:0] fwdBin;
    logic [countWidth-1:0]   fwdData;
    logic                    clearing;
    logic [binAddrWidth-1:0] clearAddr;

    logic                    ramWrite;
    logic [binAddrWidth-1:0] ramWaddr;
    logic [countWidth-1:0]   ramWdata;
    logic                    ramRead;
    logic [binAddrWidth-1:0] ramRaddr;
    logic [countWidth-1:0]   ramRdata;
    logic [countWidth-1:0]   oldCount;
    logic [countWidth-1:0]   newCount;

    // ram read overlapped the previous write to the same bin
    assign oldCount = (fwdValid && fwdBin == s1Bin) ? fwdData : ramRdata;
    assign newCount = (&oldCount) ? oldCount : oldCount + 1'b1;  // saturate

    assign ramWrite = clearing || s1Valid;
    assign ramWaddr = clearing ? clearAddr : s1Bin;
    assign ramWdata = clearing ? '0 : newCount;
    assign ramRead  = scanBusy || updValid;
    assign ramRaddr = scanBusy ? scanAddr : updBin;  // readout owns the port

    assign scanCount = ramRdata;
    assign busy      = updValid || s1Valid || cmdValid || clearing || scanBusy;

    binRam uRam (
        .clk     (clk),
        .wEnable (ramWrite),
        .waddr   (ramWaddr),
        .wdata   (ramWdata),
        .rEnable (ramRead),
        .raddr   (ramRaddr),
        .rdata   (ramRdata)
    );

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1Valid   <= 1'b0;
            fwdValid  <= 1'b0;
            clearing  <= 1'b0;
            clearAddr <= '0;
            scanStart <= 1'b0;
            scanBusy  <= 1'b0;
        end else begin
            s1Valid   <= updValid;
            fwdValid  <= s1Valid;
            scanStart <= 1'b0;

            if (cmdValid && cmdOp == opClear) begin
                clearing  <= 1'b1;
                clearAddr <= '0;
            end else if (clearing) begin
                clearAddr <= clearAddr + 1'b1;
                if (clearAddr == binAddrWidth'(binCount - 1)) begin
                    clearing <= 1'b0;  // last bin written
                end
            end

            if (cmdValid && cmdOp == opReadout) begin
                scanStart <= 1'b1;
                scanBusy  <= 1'b1;
            end else if (scanDone) begin
                scanBusy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        s1Bin   <= updBin;
        fwdBin  <= s1Bin;
        fwdData <= newCount;
    end

endmodule

`default_nettype wire

// File: hw/binDecode.sv
`timescale 1ns/100ps
`default_nettype none

module binDecode
    import histPkg::*;
(
    input  logic                    clk,
    input  logic                    res,
    input  logic                    inValid,
    input  histWord                 inWord,
    input  logic                    busy,
    output logic                    inCreditRet,
    output logic                    updValid,
    output logic [binAddrWidth-1:0] updBin,
    output logic                    cmdValid,
    output logic [1:0]              cmdOp
);

    histWord                        fifoMem [inCredits];
    logic [$clog2(inCredits)-1:0]   wrPtr;
    logic [$clog2(inCredits)-1:0]   rdPtr;
    logic [$clog2(inCredits):0]     fill;
    logic                           lastWasUpd;  // only updates may overlap

    histWord                        head;
    logic                           notEmpty;
    logic                           isCmd;
    logic                           knownOp;
    logic                           issueUpd;
    logic                           issueCmd;
    logic                           pop;

    assign head     = fifoMem[rdPtr];
    assign notEmpty = (fill != '0);
    assign isCmd    = head.cmd.kind;
    assign knownOp  = (head.cmd.op == opClear) || (head.cmd.op == opReadout);

    // updates stream behind updates, commands wait for an idle execute stage
    assign issueUpd = notEmpty && !isCmd && (!busy || lastWasUpd);
    assign issueCmd = notEmpty && isCmd && knownOp && !busy;
    assign pop      = issueUpd || issueCmd || (notEmpty && isCmd && !knownOp);

    always_ff @(posedge clk) begin
        if (inValid) begin
            fifoMem[wrPtr] <= inWord;  // source owns a credit for this slot
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            wrPtr       <= '0;
            rdPtr       <= '0;
            fill        <= '0;
            lastWasUpd  <= 1'b0;
            inCreditRet <= 1'b0;
            updValid    <= 1'b0;
            cmdValid    <= 1'b0;
        end else begin
            if (inValid) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({inValid, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: ;
            endcase
            if (issueUpd) begin
                lastWasUpd <= 1'b1;
            end else if (issueCmd) begin
                lastWasUpd <= 1'b0;
            end
            inCreditRet <= pop;  // one credit per popped slot
            updValid    <= issueUpd;
            cmdValid    <= issueCmd;
        end
    end

    always_ff @(posedge clk) begin
        if (issueUpd) begin
            updBin <= head.sample.bin;
        end
        if (issueCmd) begin
            cmdOp <= head.cmd.op;
        end
    end

endmodule

`default_nettype wire

// File: hw/binRam.sv
`timescale 1ns/100ps
`default_nettype none

module binRam
    import histPkg::*;
(
    input  logic                    clk,
    input  logic                    wEnable,
    input  logic [binAddrWidth-1:0] waddr,
    input  logic [countWidth-1:0]   wdata,
    input  logic                    rEnable,
    input  logic [binAddrWidth-1:0] raddr,
    output logic [countWidth-1:0]   rdata
);

    logic [countWidth-1:0] mem [binCount];  // one count per bin

    always_ff @(posedge clk) begin
        if (wEnable) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read; a same-cycle write to raddr shows up next access
    always_ff @(posedge clk) begin
        if (rEnable) begin
            rdata <= mem[raddr];
        end
    end

endmodule

`default_nettype wire

// File: hw/histPkg.sv
`default_nettype none

package histPkg;

    localparam int sampleWidth  = 16;  // one input word
    localparam int binAddrWidth = 6;
    localparam int binCount     = 64;
    localparam int countWidth   = 16;  // saturating bin counter

    localparam int inCredits    = 4;   // input FIFO depth
    localparam int outCredits   = 2;   // sink buffer depth

    // opcodes 0 and 3 are not defined and get dropped
    localparam logic [1:0] opClear   = 2'd1;
    localparam logic [1:0] opReadout = 2'd2;

    // one input word, read either as a sample or as a command
    typedef union packed {
        struct packed {
            logic                                kind;    // 0 here
            logic [sampleWidth-binAddrWidth-2:0] unused;
            logic [binAddrWidth-1:0]             bin;     // timestamp msbs
        } sample;
        struct packed {
            logic                   kind;    // 1 here
            logic [sampleWidth-4:0] unused;
            logic [1:0]             op;
        } cmd;
    } histWord;

endpackage

`default_nettype wire
